// ==== rtl/sd_cmd_pkg.sv ====
package sd_cmd_pkg;

    // =========================================================================
    // Frame widths
    // =========================================================================
    localparam int CMD_BITS        = 48;
    localparam int CRC7_BITS       = 7;
    localparam int RESP_SHORT_BITS = 48;
    localparam int RESP_LONG_BITS  = 136;

    // Bits covered by the CRC7 (start bit up to the last payload bit)
    localparam int CMD_DATA_BITS   = CMD_BITS - CRC7_BITS - 1;
    localparam int RESP_SHORT_BODY = RESP_SHORT_BITS - CRC7_BITS - 1;
    localparam int RESP_LONG_BODY  = RESP_LONG_BITS - CRC7_BITS - 1;

    // =========================================================================
    // Types
    // =========================================================================
    // Expected response after a command
    typedef enum logic [1:0] {
        RESP_NONE = 2'b00,
        RESP_48   = 2'b01,
        RESP_136  = 2'b10
    } resp_type_t;

    // Bit down-counter, must hold RESP_LONG_BITS
    typedef logic [7:0] resp_count_t;

    // Command word and shift register contents
    typedef logic [CMD_BITS-1:0] cmd_word_t;

endpackage

// ==== rtl/crc7_if.sv ====
interface crc7_if;

    // Clear and shift strobes from the controller
    logic       clr;
    logic       en;

    // Serial data bit from the shifter
    logic       din;

    // Running remainder, bit 6 is the next CRC bit out
    logic [6:0] crc;

    modport ctrl (output clr, output en, input crc);

    modport feed (output din, input crc);

    modport unit (input clr, input en, input din, output crc);

endinterface

// ==== rtl/crc7_unit.sv ====
module crc7_unit
    import sd_cmd_pkg::*;
(
    input  logic clk_fast,
    input  logic init_resetPulse,
    crc7_if.unit crc
);

    // x^7 + x^3 + 1, the x^7 term is implied by the feedback
    localparam logic [CRC7_BITS-1:0] POLY = 7'h09;

    logic [CRC7_BITS-1:0] crc_q;
    logic                 fb;

    // With din equal to the top bit the feedback is zero, so the
    // register just shifts out the remainder MSB first
    assign fb      = crc.din ^ crc_q[CRC7_BITS-1];
    assign crc.crc = crc_q;

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            crc_q <= '0;
        end else if (crc.clr) begin
            crc_q <= '0;
        end else if (crc.en) begin
            crc_q <= {crc_q[CRC7_BITS-2:0], 1'b0} ^ ({CRC7_BITS{fb}} & POLY);
        end
    end

    // Clear and shift come from separate FSM states in the controller
    a_clr_en_apart: assert property (
        @(posedge clk_fast) disable iff (init_resetPulse)
        !(crc.clr && crc.en)
    );

endmodule

// ==== rtl/cmd_shifter.sv ====
module cmd_shifter
    import sd_cmd_pkg::*;
#(
    parameter int TURNAROUND_CYCLES = 3
) (
    input  logic      clk_fast,
    input  logic      init_resetPulse,
    input  logic      load,
    input  cmd_word_t load_word,
    input  logic      drive,
    input  logic      crc_insert,
    input  logic      sd_cmd_in,
    output logic      sd_cmd_out,
    output logic      sd_cmd_oe,
    output logic      rx_bit,
    output cmd_word_t shift_word,
    crc7_if.feed      tx_feed,
    crc7_if.feed      rx_feed
);

    localparam int MASK_W = $clog2(TURNAROUND_CYCLES + 1);

    cmd_word_t         sreg;
    logic              oe_q;
    logic              rx_q;
    logic [MASK_W-1:0] mask_cnt;
    logic              top_bit;

    // CRC bits take the place of the top bit during insertion
    assign top_bit     = crc_insert ? tx_feed.crc[CRC7_BITS-1] : sreg[CMD_BITS-1];
    assign sd_cmd_out  = top_bit;
    assign sd_cmd_oe   = oe_q;
    assign rx_bit      = rx_q;
    assign shift_word  = sreg;
    assign tx_feed.din = top_bit;
    assign rx_feed.din = rx_q;

    // Shared command / response shift register, MSB leaves first
    always_ff @(posedge clk_fast) begin
        if (load) begin
            sreg <= load_word;
        end else begin
            sreg <= {sreg[CMD_BITS-2:0], rx_q};
        end
    end

    // Output enable follows drive by one cycle, then the line is
    // ignored while it turns around to the card
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            oe_q     <= 1'b0;
            rx_q     <= 1'b1;
            mask_cnt <= '0;
        end else begin
            oe_q <= drive;
            rx_q <= (oe_q || (mask_cnt != '0)) ? 1'b1 : sd_cmd_in;
            if (oe_q) begin
                mask_cnt <= MASK_W'(TURNAROUND_CYCLES);
            end else if (mask_cnt != '0) begin
                mask_cnt <= mask_cnt - 1'b1;
            end
        end
    end

    a_no_load_while_driving: assert property (
        @(posedge clk_fast) disable iff (init_resetPulse)
        !(load && sd_cmd_oe)
    );

endmodule

// ==== rtl/sd_cmd_ctrl.sv ====
module sd_cmd_ctrl
    import sd_cmd_pkg::*;
(
    input  logic       clk_fast,
    input  logic       init_resetPulse,
    input  logic       cmd_trigger,
    input  resp_type_t cmd_resp_type,
    input  logic       rx_bit,
    input  cmd_word_t  shift_word,
    output logic       load,
    output logic       drive,
    output logic       crc_insert,
    crc7_if.ctrl       tx_crc,
    crc7_if.ctrl       rx_crc,
    output logic       cmd_done,
    output logic       resp_done,
    output cmd_word_t  resp_data,
    output logic       resp_crc_err
);

    typedef enum logic [2:0] {
        C_IDLE,
        C_CLR,
        C_DATA,
        C_CRC,
        C_END,
        C_DONE
    } cmd_state_t;

    typedef enum logic [2:0] {
        R_IDLE,
        R_WAIT,
        R_BODY,
        R_CRC,
        R_END
    } resp_state_t;

    cmd_state_t  cmd_state;
    resp_state_t resp_state;
    resp_count_t cmd_cnt;
    resp_count_t resp_cnt;
    resp_count_t body_start;
    logic        trig_q;
    logic        trig_seen;

    // A toggle during a command waits until the command is out
    assign trig_seen = (cmd_state == C_IDLE) && (cmd_trigger != trig_q);

    // Start bit is consumed in R_WAIT, the rest of the body is counted here
    assign body_start = (cmd_resp_type == RESP_136) ? resp_count_t'(RESP_LONG_BODY - 2)
                                                    : resp_count_t'(RESP_SHORT_BODY - 2);

    // =========================================================================
    // Shifter and CRC strobes
    // =========================================================================
    assign load       = (cmd_state == C_CLR);
    assign drive      = (cmd_state == C_CLR) || (cmd_state == C_DATA) || (cmd_state == C_CRC);
    assign crc_insert = (cmd_state == C_CRC);

    assign tx_crc.clr = (cmd_state == C_CLR);
    assign tx_crc.en  = (cmd_state == C_DATA) || (cmd_state == C_CRC);

    // Idle line keeps the rx CRC cleared; the start bit is its first input
    assign rx_crc.clr = (resp_state == R_WAIT) && rx_bit;
    assign rx_crc.en  = ((resp_state == R_WAIT) && !rx_bit) ||
                        (resp_state == R_BODY) || (resp_state == R_CRC);

    // =========================================================================
    // Command and response FSMs
    // =========================================================================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            cmd_state    <= C_IDLE;
            resp_state   <= R_IDLE;
            cmd_cnt      <= '0;
            resp_cnt     <= '0;
            trig_q       <= 1'b0;
            cmd_done     <= 1'b0;
            resp_done    <= 1'b0;
            resp_crc_err <= 1'b0;
        end else begin
            if (cmd_state == C_IDLE) begin
                trig_q <= cmd_trigger;
            end

            case (resp_state)
                R_WAIT: begin
                    if (!rx_bit) begin
                        resp_crc_err <= 1'b0;
                        resp_cnt     <= body_start;
                        resp_state   <= R_BODY;
                    end
                end
                R_BODY: begin
                    if (resp_cnt == '0) begin
                        resp_cnt   <= resp_count_t'(CRC7_BITS - 1);
                        resp_state <= R_CRC;
                    end else begin
                        resp_cnt <= resp_cnt - 1'b1;
                    end
                end
                R_CRC: begin
                    // Bitwise compare against the remainder as it shifts out
                    if (rx_bit != rx_crc.crc[CRC7_BITS-1]) begin
                        resp_crc_err <= 1'b1;
                    end
                    if (resp_cnt == '0) begin
                        resp_state <= R_END;
                    end else begin
                        resp_cnt <= resp_cnt - 1'b1;
                    end
                end
                R_END: begin
                    if (!rx_bit) begin
                        resp_crc_err <= 1'b1;
                    end
                    resp_done  <= !resp_done;
                    resp_state <= R_IDLE;
                end
                default: begin
                end
            endcase

            // Command FSM comes last so an abort wins over the response FSM
            case (cmd_state)
                C_IDLE: begin
                    if (trig_seen) begin
                        resp_state <= R_IDLE;
                        cmd_state  <= C_CLR;
                    end
                end
                C_CLR: begin
                    cmd_cnt   <= resp_count_t'(CMD_DATA_BITS - 1);
                    cmd_state <= C_DATA;
                end
                C_DATA: begin
                    if (cmd_cnt == '0) begin
                        cmd_cnt   <= resp_count_t'(CRC7_BITS - 1);
                        cmd_state <= C_CRC;
                    end else begin
                        cmd_cnt <= cmd_cnt - 1'b1;
                    end
                end
                C_CRC: begin
                    if (cmd_cnt == '0) begin
                        cmd_state <= C_END;
                    end else begin
                        cmd_cnt <= cmd_cnt - 1'b1;
                    end
                end
                C_END: begin
                    cmd_state <= C_DONE;
                end
                C_DONE: begin
                    cmd_done   <= !cmd_done;
                    resp_state <= (cmd_resp_type == RESP_NONE) ? R_IDLE : R_WAIT;
                    cmd_state  <= C_IDLE;
                end
                default: begin
                    cmd_state <= C_IDLE;
                end
            endcase
        end
    end

    // Last 48 bits of the response, end bit included
    always_ff @(posedge clk_fast) begin
        if (resp_state == R_END) begin
            resp_data <= {shift_word[CMD_BITS-2:0], rx_bit};
        end
    end

    // Response type picks the body length at the start bit, so it holds until then
    a_resp_type_stable: assert property (
        @(posedge clk_fast) disable iff (init_resetPulse)
        ((resp_state == R_WAIT) && !trig_seen) |-> $stable(cmd_resp_type)
    );

endmodule

// ==== rtl/sd_cmd_top.sv ====
module sd_cmd_top
    import sd_cmd_pkg::*;
#(
    parameter int TURNAROUND_CYCLES = 3
) (
    input  logic       clk_fast,
    input  logic       init_resetPulse,
    input  logic       cmd_trigger,
    input  cmd_word_t  cmd_data,
    input  resp_type_t cmd_resp_type,
    input  logic       sd_cmd_in,
    output logic       sd_cmd_out,
    output logic       sd_cmd_oe,
    output logic       cmd_done,
    output logic       resp_done,
    output cmd_word_t  resp_data,
    output logic       resp_crc_err
);

    logic      load;
    logic      drive;
    logic      crc_insert;
    logic      rx_bit;
    cmd_word_t shift_word;

    // tx side checks the outgoing top bit, rx side the staged input
    crc7_if tx_crc ();
    crc7_if rx_crc ();

    sd_cmd_ctrl u_ctrl (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_trigger     (cmd_trigger),
        .cmd_resp_type   (cmd_resp_type),
        .rx_bit          (rx_bit),
        .shift_word      (shift_word),
        .load            (load),
        .drive           (drive),
        .crc_insert      (crc_insert),
        .tx_crc          (tx_crc),
        .rx_crc          (rx_crc),
        .cmd_done        (cmd_done),
        .resp_done       (resp_done),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err)
    );

    cmd_shifter #(
        .TURNAROUND_CYCLES (TURNAROUND_CYCLES)
    ) u_shifter (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .load            (load),
        .load_word       (cmd_data),
        .drive           (drive),
        .crc_insert      (crc_insert),
        .sd_cmd_in       (sd_cmd_in),
        .sd_cmd_out      (sd_cmd_out),
        .sd_cmd_oe       (sd_cmd_oe),
        .rx_bit          (rx_bit),
        .shift_word      (shift_word),
        .tx_feed         (tx_crc),
        .rx_feed         (rx_crc)
    );

    crc7_unit u_tx_crc (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .crc             (tx_crc)
    );

    crc7_unit u_rx_crc (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .crc             (rx_crc)
    );

endmodule

// ==== dv/tb_sd_cmd.sv ====
module tb_sd_cmd
    import sd_cmd_pkg::*;
;

    logic       clk_fast;
    logic       init_resetPulse;
    logic       cmd_trigger;
    cmd_word_t  cmd_data;
    resp_type_t cmd_resp_type;
    logic       sd_cmd_in;
    logic       sd_cmd_out;
    logic       sd_cmd_oe;
    logic       cmd_done;
    logic       resp_done;
    cmd_word_t  resp_data;
    logic       resp_crc_err;

    // Pattern table, one entry per line of the data file
    string        p_name[$];
    cmd_word_t    p_cmd[$];
    int           p_type[$];
    logic [135:0] p_resp[$];
    cmd_word_t    p_exp[$];
    int           p_err[$];
    int           p_abort[$];

    int cycles;
    int cycle_limit;

    sd_cmd_top #(
        .TURNAROUND_CYCLES (3)
    ) u_dut (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_trigger     (cmd_trigger),
        .cmd_data        (cmd_data),
        .cmd_resp_type   (cmd_resp_type),
        .sd_cmd_in       (sd_cmd_in),
        .sd_cmd_out      (sd_cmd_out),
        .sd_cmd_oe       (sd_cmd_oe),
        .cmd_done        (cmd_done),
        .resp_done       (resp_done),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err)
    );

    always #20 clk_fast = ~clk_fast;

    // Hang guard, the limit is set once the patterns are known
    always @(posedge clk_fast) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout: the DUT stopped responding after %0d cycles", cycles);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    task automatic check(input string test, input string what,
                         input logic [135:0] expected, input logic [135:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected %0h actual %0h", test, what, expected, actual);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // CRC7 with x^7 + x^3 + 1 over bits[len-1:0], MSB first
    function automatic logic [6:0] crc7_of(input logic [135:0] bits, input int len);
        logic [6:0] r;
        logic       fb;
        int         k;
        r = '0;
        for (k = len - 1; k >= 0; k--) begin
            fb = bits[k] ^ r[6];
            r  = {r[5:0], 1'b0};
            if (fb) begin
                r = r ^ 7'h09;
            end
        end
        return r;
    endfunction

    task automatic load_patterns();
        int        fd;
        int        code;
        int        got;
        string     line;
        string     n;
        cmd_word_t c;
        int        t;
        logic [135:0] r;
        cmd_word_t e;
        int        er;
        int        ab;
        fd = $fopen("dv/sd_cmd_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file dv/sd_cmd_patterns.txt");
            $display("** FAIL **");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                got = $sscanf(line, "%s %h %d %h %h %d %d", n, c, t, r, e, er, ab);
                if (got == 7) begin
                    p_name.push_back(n);
                    p_cmd.push_back(c);
                    p_type.push_back(t);
                    p_resp.push_back(r);
                    p_exp.push_back(e);
                    p_err.push_back(er);
                    p_abort.push_back(ab);
                end
            end
        end
        $fclose(fd);
        if (p_name.size() == 0) begin
            $display("The pattern file holds no test lines");
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // Toggle the trigger, collect the serial command, check cmd_done timing
    task automatic send_command(input int idx);
        cmd_word_t bits;
        cmd_word_t expected;
        logic      done0;
        int        n;
        done0          = cmd_done;
        cmd_data       = p_cmd[idx];
        cmd_resp_type  = resp_type_t'(p_type[idx]);
        cmd_trigger    = ~cmd_trigger;
        while (!sd_cmd_oe) begin
            @(negedge clk_fast);
        end
        n    = 0;
        bits = '0;
        while (sd_cmd_oe) begin
            bits = {bits[CMD_BITS-2:0], sd_cmd_out};
            n++;
            @(negedge clk_fast);
        end
        expected = {p_cmd[idx][47:8], crc7_of({96'h0, p_cmd[idx][47:8]}, 40), p_cmd[idx][0]};
        check(p_name[idx], "oe_cycles", 136'(48), 136'(n));
        check(p_name[idx], "cmd_bits", 136'(expected), 136'(bits));
        check(p_name[idx], "cmd_file", 136'(p_cmd[idx]), 136'(bits));
        check(p_name[idx], "cmd_done_early", 136'(done0), 136'(cmd_done));
        @(negedge clk_fast);
        check(p_name[idx], "cmd_done", 136'(!done0), 136'(cmd_done));
    endtask

    // Card model: idle gap of 1s, then the first nbits of the response
    task automatic drive_response(input logic [135:0] resp, input int len, input int nbits);
        int gap;
        int i;
        gap = 4 + ($urandom % 17);
        repeat (gap) @(negedge clk_fast);
        for (i = len - 1; i >= len - nbits; i--) begin
            sd_cmd_in = resp[i];
            @(negedge clk_fast);
        end
        sd_cmd_in = 1'b1;
    endtask

    task automatic run_pattern(input int idx);
        logic         c0;
        logic         r0;
        int           len;
        logic [135:0] resp;
        logic [6:0]   crc;
        logic         exp_err;
        c0   = cmd_done;
        r0   = resp_done;
        resp = p_resp[idx];
        len  = (p_type[idx] == 2) ? RESP_LONG_BITS : RESP_SHORT_BITS;
        if (p_abort[idx] != 0) begin
            // Partial answer, then a new trigger cuts it off
            send_command(idx);
            drive_response(resp, len, 20);
            c0 = cmd_done;
        end
        send_command(idx);
        if (p_abort[idx] != 0) begin
            check(p_name[idx], "resp_done_abort", 136'(r0), 136'(resp_done));
        end
        if (p_type[idx] == 0) begin
            // The card answers anyway and the DUT must not listen
            drive_response(resp, RESP_SHORT_BITS, RESP_SHORT_BITS);
            repeat (200) @(negedge clk_fast);
            check(p_name[idx], "resp_done_none", 136'(r0), 136'(resp_done));
        end else begin
            crc     = crc7_of(resp >> 8, len - 8);
            exp_err = (crc != resp[7:1]) || !resp[0];
            check(p_name[idx], "file_resp_data", 136'(resp[47:0]), 136'(p_exp[idx]));
            check(p_name[idx], "file_crc_err", 136'(exp_err), 136'(p_err[idx]));
            drive_response(resp, len, len);
            while (resp_done == r0) begin
                @(negedge clk_fast);
            end
            check(p_name[idx], "resp_data", 136'(resp[47:0]), 136'(resp_data));
            check(p_name[idx], "resp_crc_err", 136'(exp_err), 136'(resp_crc_err));
        end
        check(p_name[idx], "cmd_done_count", 136'(!c0), 136'(cmd_done));
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        void'($urandom(32'hf5f));
        clk_fast        = 1'b0;
        init_resetPulse = 1'b1;
        cmd_trigger     = 1'b0;
        cmd_data        = '0;
        cmd_resp_type   = RESP_NONE;
        sd_cmd_in       = 1'b1;
        cycles          = 0;
        cycle_limit     = 0;
        load_patterns();
        cycle_limit = p_name.size() * 300 + 20;
        repeat (4) @(posedge clk_fast);
        @(negedge clk_fast);
        init_resetPulse = 1'b0;
        check("reset", "sd_cmd_oe", 136'(0), 136'(sd_cmd_oe));
        check("reset", "cmd_done", 136'(0), 136'(cmd_done));
        check("reset", "resp_done", 136'(0), 136'(resp_done));
        check("reset", "resp_crc_err", 136'(0), 136'(resp_crc_err));
        @(negedge clk_fast);
        for (int i = 0; i < p_name.size(); i++) begin
            run_pattern(i);
            repeat (2) @(negedge clk_fast);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== dv/sd_cmd_patterns.txt ====
# name cmd_data resp_type(0 none,1 r48,2 r136) resp_bits_hex expected_resp_data crc_err abort
# resp_bits holds the response right aligned, sent MSB first
cmd0_none 400000000095 0 0 0 0 0
cmd8_r48_good 48000001AA87 1 08000001AA13 08000001AA13 0 0
cmd8_r48_badcrc 48000001AA87 1 08000001AA11 08000001AA11 1 0
cmd8_r48_recover 48000001AA87 1 400000000095 400000000095 0 0
cmd8_r48_endbit 48000001AA87 1 08000001AA12 08000001AA12 1 0
cmd0_r48_clear 400000000095 1 48000001AA87 48000001AA87 0 0
cmd2_r136_good 400000000095 2 000000000000000000000048000001AA87 48000001AA87 0 0
cmd2_r136_badcrc 400000000095 2 000000000000000000000008000001AA87 08000001AA87 1 0
cmd2_r136_tail 48000001AA87 2 0000000000000000000000400000000095 400000000095 0 0
cmd8_abort 48000001AA87 1 08000001AA13 08000001AA13 0 1
cmd0_after_abort 400000000095 1 400000000095 400000000095 0 0

// ==== tb.f ====
rtl/sd_cmd_pkg.sv
rtl/crc7_if.sv
rtl/crc7_unit.sv
rtl/cmd_shifter.sv
rtl/sd_cmd_ctrl.sv
rtl/sd_cmd_top.sv
dv/tb_sd_cmd.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SD CMD engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sd_cmd \
    -f tb.f -o sim_tb_sd_cmd
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb_sd_cmd > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
